// ==== rcu_pkg.sv ====
// rename and reorder unit types
package rcu_pkg;

    localparam int xlen = 64;
    localparam int pc_width = 32;
    localparam int arch_regs = 32;

    // default sizes, overridden from the top level
    localparam int default_rob_size = 16;
    localparam int default_phys_regs = 64;

    // widest tag and line that fit the shared structs
    localparam int tag_max_width = 6;
    localparam int line_max_width = 4;

    typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;
    typedef logic [tag_max_width-1:0] tag_t;
    typedef logic [line_max_width-1:0] line_t;
    typedef logic [3:0] ecause_t;

    // decode to rename bundle
    typedef struct packed {
        logic [pc_width-1:0] pc;
        logic [31:0] imm;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic use_rs1;
        logic use_rs2;
        logic use_rd;
        logic is_lsu;
        logic exception;
        ecause_t ecause;
    } dispatch_t;

    // one function unit result
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic [xlen-1:0] data;
        line_t line;
    } wb_t;

    typedef struct packed {
        logic valid;
        logic exception;
        ecause_t ecause;
        logic [pc_width-1:0] pc;
    } commit_t;

    // rob entry as seen by the issue pointer
    typedef struct packed {
        logic pending;
        logic exception;
        logic is_lsu;
        logic [pc_width-1:0] pc;
        logic [31:0] imm;
        tag_t rs1_tag;
        tag_t rs2_tag;
        tag_t new_tag;
    } iss_entry_t;

    typedef struct packed {
        logic is_lsu;
        line_t line;
        tag_t tag;
        logic [pc_width-1:0] pc;
        logic [31:0] imm;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
    } issue_t;

endpackage

// ==== free_tag_pool.sv ====
// free physical tag bitmap
module free_tag_pool #(
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic alloc,
    output logic [$clog2(phys_regs)-1:0] alloc_tag,
    output logic empty,
    input  logic commit,
    input  logic [$clog2(phys_regs)-1:0] commit_new_tag,
    input  logic [$clog2(phys_regs)-1:0] commit_old_tag
);
    localparam int tag_w = $clog2(phys_regs);

    logic [phys_regs-1:0] free_q;
    // tags held by the committed map, tag 0 always included
    logic [phys_regs-1:0] committed_q;

    // lowest free tag wins, tag 0 is never handed out
    always_comb begin
        alloc_tag = '0;
        for (int i = phys_regs - 1; i > 0; i--) begin
            if (free_q[i]) begin
                alloc_tag = tag_w'(i);
            end
        end
    end

    assign empty = ~|free_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            free_q <= {{(phys_regs - 1){1'b1}}, 1'b0};
            committed_q <= {{(phys_regs - 1){1'b0}}, 1'b1};
        end else if (flush) begin
            // everything not in the committed map is free again
            free_q <= ~committed_q;
        end else begin
            if (alloc) begin
                free_q[alloc_tag] <= 1'b0;
            end
            if (commit) begin
                committed_q[commit_new_tag] <= 1'b1;
                if (commit_old_tag != '0) begin
                    committed_q[commit_old_tag] <= 1'b0;
                    free_q[commit_old_tag] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rename_map.sv ====
// speculative and committed rename tables
module rename_map #(
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  rcu_pkg::arch_reg_t rs1,
    input  rcu_pkg::arch_reg_t rs2,
    input  rcu_pkg::arch_reg_t rd,
    output logic [$clog2(phys_regs)-1:0] rs1_tag,
    output logic [$clog2(phys_regs)-1:0] rs2_tag,
    output logic [$clog2(phys_regs)-1:0] old_tag,
    input  logic rename,
    input  logic [$clog2(phys_regs)-1:0] new_tag,
    input  logic commit,
    input  rcu_pkg::arch_reg_t commit_rd,
    input  logic [$clog2(phys_regs)-1:0] commit_tag
);
    localparam int tag_w = $clog2(phys_regs);

    logic [tag_w-1:0] spec_map [rcu_pkg::arch_regs];
    logic [tag_w-1:0] comm_map [rcu_pkg::arch_regs];

    // entry 0 is never written, so x0 stays on tag 0
    assign rs1_tag = spec_map[rs1];
    assign rs2_tag = spec_map[rs2];
    assign old_tag = spec_map[rd];

    // speculative table, updated at dispatch
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rcu_pkg::arch_regs; i++) begin
                spec_map[i] <= '0;
            end
        end else if (flush) begin
            spec_map <= comm_map;
        end else if (rename && (rd != '0)) begin
            spec_map[rd] <= new_tag;
        end
    end

    // committed table, updated at retirement
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rcu_pkg::arch_regs; i++) begin
                comm_map[i] <= '0;
            end
        end else if (commit && (commit_rd != '0)) begin
            comm_map[commit_rd] <= commit_tag;
        end
    end

endmodule

// ==== phys_regfile.sv ====
// physical register file with ready bits
module phys_regfile #(
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic [$clog2(phys_regs)-1:0] rs1_tag,
    input  logic [$clog2(phys_regs)-1:0] rs2_tag,
    output logic [rcu_pkg::xlen-1:0] rs1_data,
    output logic [rcu_pkg::xlen-1:0] rs2_data,
    output logic rs1_ready,
    output logic rs2_ready,
    input  logic alloc,
    input  logic [$clog2(phys_regs)-1:0] alloc_tag,
    input  rcu_pkg::wb_t wb_alu,
    input  rcu_pkg::wb_t wb_lsu
);
    localparam int tag_w = $clog2(phys_regs);

    logic [rcu_pkg::xlen-1:0] data_q [phys_regs];
    logic [phys_regs-1:0] ready_q;
    logic [tag_w-1:0] alu_tag;
    logic [tag_w-1:0] lsu_tag;

    assign alu_tag = wb_alu.tag[tag_w-1:0];
    assign lsu_tag = wb_lsu.tag[tag_w-1:0];

    // both ports may write in one cycle, never to the same tag
    always_ff @(posedge clk) begin
        if (wb_alu.valid && (alu_tag != '0)) begin
            data_q[alu_tag] <= wb_alu.data;
        end
        if (wb_lsu.valid && (lsu_tag != '0)) begin
            data_q[lsu_tag] <= wb_lsu.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= '1;
        end else begin
            // fresh destination waits for its result
            if (alloc) begin
                ready_q[alloc_tag] <= 1'b0;
            end
            if (wb_alu.valid) begin
                ready_q[alu_tag] <= 1'b1;
            end
            if (wb_lsu.valid) begin
                ready_q[lsu_tag] <= 1'b1;
            end
        end
    end

    // tag 0 is the hardwired zero register
    assign rs1_data = (rs1_tag == '0) ? '0 : data_q[rs1_tag];
    assign rs2_data = (rs2_tag == '0) ? '0 : data_q[rs2_tag];
    assign rs1_ready = (rs1_tag == '0) || ready_q[rs1_tag];
    assign rs2_ready = (rs2_tag == '0) || ready_q[rs2_tag];

endmodule

// ==== rob_store.sv ====
// reorder buffer storage and commit
module rob_store #(
    parameter int rob_size = rcu_pkg::default_rob_size,
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic dispatch_valid,
    output logic dispatch_ready,
    input  rcu_pkg::dispatch_t dispatch,
    input  logic [$clog2(phys_regs)-1:0] rs1_tag,
    input  logic [$clog2(phys_regs)-1:0] rs2_tag,
    input  logic [$clog2(phys_regs)-1:0] old_tag,
    input  logic [$clog2(phys_regs)-1:0] new_tag,
    input  logic pool_empty,
    output logic accept,
    output logic [$clog2(rob_size)-1:0] write_line,
    input  logic [$clog2(rob_size)-1:0] iss_line,
    output rcu_pkg::iss_entry_t iss_entry,
    input  logic iss_done,
    input  rcu_pkg::wb_t wb_alu,
    input  rcu_pkg::wb_t wb_lsu,
    output rcu_pkg::commit_t commit,
    output rcu_pkg::arch_reg_t commit_rd,
    output logic [$clog2(phys_regs)-1:0] commit_new_tag,
    output logic [$clog2(phys_regs)-1:0] commit_old_tag,
    output logic commit_fire
);
    localparam int tag_w = $clog2(phys_regs);
    localparam int line_w = $clog2(rob_size);

    // payload
    logic [rcu_pkg::pc_width-1:0] pc_q [rob_size];
    logic [31:0] imm_q [rob_size];
    rcu_pkg::ecause_t ecause_q [rob_size];
    rcu_pkg::arch_reg_t rd_q [rob_size];
    logic [tag_w-1:0] rs1_tag_q [rob_size];
    logic [tag_w-1:0] rs2_tag_q [rob_size];
    logic [tag_w-1:0] new_tag_q [rob_size];
    logic [tag_w-1:0] old_tag_q [rob_size];
    logic [rob_size-1:0] is_lsu_q;
    logic [rob_size-1:0] except_q;

    // entry status
    logic [rob_size-1:0] occupied;
    logic [rob_size-1:0] issued;
    logic [rob_size-1:0] finish;
    logic [line_w-1:0] wr_ptr;
    logic [line_w-1:0] cm_ptr;
    logic trap_pending;

    logic take;
    logic cm_valid;

    function automatic logic [line_w-1:0] next_line(input logic [line_w-1:0] line);
        return (line == line_w'(rob_size - 1)) ? '0 : line + 1'b1;
    endfunction

    assign dispatch_ready = !occupied[wr_ptr] && !pool_empty && !flush;
    assign take = dispatch_valid && dispatch_ready;
    // only a real destination takes a tag, excepting entries never write back
    assign accept = take && dispatch.use_rd && (dispatch.rd != '0) && !dispatch.exception;
    assign write_line = wr_ptr;

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q[wr_ptr] <= dispatch.pc;
            imm_q[wr_ptr] <= dispatch.imm;
            ecause_q[wr_ptr] <= dispatch.ecause;
            is_lsu_q[wr_ptr] <= dispatch.is_lsu;
            except_q[wr_ptr] <= dispatch.exception;
            // unused sources read tag 0
            rs1_tag_q[wr_ptr] <= dispatch.use_rs1 ? rs1_tag : '0;
            rs2_tag_q[wr_ptr] <= dispatch.use_rs2 ? rs2_tag : '0;
            rd_q[wr_ptr] <= accept ? dispatch.rd : '0;
            new_tag_q[wr_ptr] <= accept ? new_tag : '0;
            old_tag_q[wr_ptr] <= accept ? old_tag : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= '0;
            issued <= '0;
            finish <= '0;
            wr_ptr <= '0;
            cm_ptr <= '0;
            trap_pending <= 1'b0;
        end else if (flush) begin
            occupied <= '0;
            issued <= '0;
            finish <= '0;
            cm_ptr <= wr_ptr;
            trap_pending <= 1'b0;
        end else begin
            if (take) begin
                occupied[wr_ptr] <= 1'b1;
                issued[wr_ptr] <= 1'b0;
                // an excepting entry has nothing to execute
                finish[wr_ptr] <= dispatch.exception;
                wr_ptr <= next_line(wr_ptr);
            end
            if (iss_done) begin
                issued[iss_line] <= 1'b1;
            end
            if (wb_alu.valid) begin
                finish[wb_alu.line[line_w-1:0]] <= 1'b1;
            end
            if (wb_lsu.valid) begin
                finish[wb_lsu.line[line_w-1:0]] <= 1'b1;
            end
            if (cm_valid) begin
                occupied[cm_ptr] <= 1'b0;
                issued[cm_ptr] <= 1'b0;
                finish[cm_ptr] <= 1'b0;
                cm_ptr <= next_line(cm_ptr);
                if (except_q[cm_ptr]) begin
                    trap_pending <= 1'b1;
                end
            end
        end
    end

    // an excepting entry also waits for the issue pointer to step past it
    assign cm_valid = occupied[cm_ptr] && issued[cm_ptr] && finish[cm_ptr]
                      && !trap_pending && !flush;
    assign commit_fire = cm_valid && !except_q[cm_ptr];

    always_comb begin
        commit.valid = cm_valid;
        commit.exception = except_q[cm_ptr];
        commit.ecause = ecause_q[cm_ptr];
        commit.pc = pc_q[cm_ptr];
    end

    assign commit_rd = rd_q[cm_ptr];
    assign commit_new_tag = new_tag_q[cm_ptr];
    assign commit_old_tag = old_tag_q[cm_ptr];

    always_comb begin
        iss_entry.pending = occupied[iss_line] && !issued[iss_line];
        iss_entry.exception = except_q[iss_line];
        iss_entry.is_lsu = is_lsu_q[iss_line];
        iss_entry.pc = pc_q[iss_line];
        iss_entry.imm = imm_q[iss_line];
        iss_entry.rs1_tag = rcu_pkg::tag_t'(rs1_tag_q[iss_line]);
        iss_entry.rs2_tag = rcu_pkg::tag_t'(rs2_tag_q[iss_line]);
        iss_entry.new_tag = rcu_pkg::tag_t'(new_tag_q[iss_line]);
    end

endmodule

// ==== issue_stage.sv ====
// in-order issue to alu and lsu
module issue_stage #(
    parameter int rob_size = rcu_pkg::default_rob_size,
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic [$clog2(rob_size)-1:0] write_line,
    output logic [$clog2(rob_size)-1:0] iss_line,
    input  rcu_pkg::iss_entry_t iss_entry,
    input  logic rs1_ready,
    input  logic rs2_ready,
    input  logic [rcu_pkg::xlen-1:0] rs1_data,
    input  logic [rcu_pkg::xlen-1:0] rs2_data,
    input  logic alu_ready,
    input  logic lsu_ready,
    output logic issue_valid,
    output rcu_pkg::issue_t issue,
    output logic iss_done
);
    localparam int tag_w = $clog2(phys_regs);
    localparam int line_w = $clog2(rob_size);

    logic [line_w-1:0] iss_ptr;
    logic pending;
    logic unit_ready;
    logic step;

    assign iss_line = iss_ptr;
    assign pending = iss_entry.pending && !flush;
    assign issue_valid = pending && !iss_entry.exception && rs1_ready && rs2_ready;
    assign unit_ready = iss_entry.is_lsu ? lsu_ready : alu_ready;
    // excepting entries are passed over without a bundle
    assign step = pending && iss_entry.exception;
    assign iss_done = (issue_valid && unit_ready) || step;

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_ptr <= '0;
        end else if (flush) begin
            iss_ptr <= write_line;
        end else if (iss_done) begin
            iss_ptr <= (iss_ptr == line_w'(rob_size - 1)) ? '0 : iss_ptr + 1'b1;
        end
    end

    // bundle stays put while the unit holds off
    always_comb begin
        issue.is_lsu = iss_entry.is_lsu;
        issue.line = rcu_pkg::line_t'(iss_ptr);
        issue.tag = rcu_pkg::tag_t'(iss_entry.new_tag[tag_w-1:0]);
        issue.pc = iss_entry.pc;
        issue.imm = iss_entry.imm;
        issue.rs1_data = rs1_data;
        issue.rs2_data = rs2_data;
    end

endmodule

// ==== rcu_top.sv ====
// rename and reorder unit
module rcu_top #(
    parameter int rob_size = rcu_pkg::default_rob_size,
    parameter int phys_regs = rcu_pkg::default_phys_regs
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic dispatch_valid,
    input  rcu_pkg::dispatch_t dispatch,
    output logic dispatch_ready,
    input  logic alu_ready,
    input  logic lsu_ready,
    output logic issue_valid,
    output rcu_pkg::issue_t issue,
    input  rcu_pkg::wb_t wb_alu,
    input  rcu_pkg::wb_t wb_lsu,
    output rcu_pkg::commit_t commit
);
    localparam int tag_w = $clog2(phys_regs);
    localparam int line_w = $clog2(rob_size);

    // tags and lines must fit the shared structs
    if ((phys_regs > (1 << rcu_pkg::tag_max_width))
        || (rob_size > (1 << rcu_pkg::line_max_width))) begin : g_size_check
        $error("rcu_top sizes exceed the widths of the shared structs");
    end

    logic [tag_w-1:0] alloc_tag;
    logic [tag_w-1:0] ren_rs1_tag;
    logic [tag_w-1:0] ren_rs2_tag;
    logic [tag_w-1:0] ren_old_tag;
    logic [tag_w-1:0] commit_new_tag;
    logic [tag_w-1:0] commit_old_tag;
    logic pool_empty;
    logic accept;
    logic commit_fire;
    logic iss_done;
    logic rs1_ready;
    logic rs2_ready;
    logic [rcu_pkg::xlen-1:0] rs1_data;
    logic [rcu_pkg::xlen-1:0] rs2_data;
    logic [line_w-1:0] write_line;
    logic [line_w-1:0] iss_line;
    rcu_pkg::arch_reg_t commit_rd;
    rcu_pkg::iss_entry_t iss_entry;

    free_tag_pool #(.phys_regs(phys_regs)) u_pool (
        .clk(clk), .reset(reset), .flush(flush),
        .alloc(accept), .alloc_tag(alloc_tag), .empty(pool_empty),
        .commit(commit_fire), .commit_new_tag(commit_new_tag),
        .commit_old_tag(commit_old_tag)
    );

    rename_map #(.phys_regs(phys_regs)) u_map (
        .clk(clk), .reset(reset), .flush(flush),
        .rs1(dispatch.rs1), .rs2(dispatch.rs2), .rd(dispatch.rd),
        .rs1_tag(ren_rs1_tag), .rs2_tag(ren_rs2_tag), .old_tag(ren_old_tag),
        .rename(accept), .new_tag(alloc_tag),
        .commit(commit_fire), .commit_rd(commit_rd), .commit_tag(commit_new_tag)
    );

    phys_regfile #(.phys_regs(phys_regs)) u_prf (
        .clk(clk), .reset(reset),
        .rs1_tag(iss_entry.rs1_tag[tag_w-1:0]), .rs2_tag(iss_entry.rs2_tag[tag_w-1:0]),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .alloc(accept), .alloc_tag(alloc_tag),
        .wb_alu(wb_alu), .wb_lsu(wb_lsu)
    );

    rob_store #(.rob_size(rob_size), .phys_regs(phys_regs)) u_rob (
        .clk(clk), .reset(reset), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .dispatch(dispatch),
        .rs1_tag(ren_rs1_tag), .rs2_tag(ren_rs2_tag), .old_tag(ren_old_tag),
        .new_tag(alloc_tag), .pool_empty(pool_empty), .accept(accept),
        .write_line(write_line), .iss_line(iss_line), .iss_entry(iss_entry),
        .iss_done(iss_done), .wb_alu(wb_alu), .wb_lsu(wb_lsu),
        .commit(commit), .commit_rd(commit_rd),
        .commit_new_tag(commit_new_tag), .commit_old_tag(commit_old_tag),
        .commit_fire(commit_fire)
    );

    issue_stage #(.rob_size(rob_size), .phys_regs(phys_regs)) u_issue (
        .clk(clk), .reset(reset), .flush(flush),
        .write_line(write_line), .iss_line(iss_line), .iss_entry(iss_entry),
        .rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_ready(alu_ready), .lsu_ready(lsu_ready),
        .issue_valid(issue_valid), .issue(issue), .iss_done(iss_done)
    );

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset
module tb_clock_gen #(
    parameter int period = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset released on a rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb_rcu_assert.sv ====
// rename unit protocol assertions
module tb_rcu_assert (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic alu_ready,
    input logic lsu_ready,
    input logic issue_valid,
    input rcu_pkg::issue_t issue,
    input rcu_pkg::commit_t commit
);

    logic trap_seen;
    logic unit_ready;
    int fail_count = 0;

    assign unit_ready = issue.is_lsu ? lsu_ready : alu_ready;

    // exception retired, waiting for the flush
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            trap_seen <= 1'b0;
        end else if (commit.valid && commit.exception) begin
            trap_seen <= 1'b1;
        end
    end

    a_commit_in_reset: assert property (@(posedge clk) reset |=> (!reset || !commit.valid))
        else begin
            $error("commit valid while reset is high");
            fail_count++;
        end

    a_issue_after_reset: assert property (@(posedge clk) $fell(reset) |-> !issue_valid)
        else begin
            $error("issue valid in the first cycle after reset");
            fail_count++;
        end

    a_held_bundle: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !unit_ready && !flush) |=> (flush || (issue_valid && $stable(issue))))
        else begin
            $error("issue bundle changed while the unit was not ready");
            fail_count++;
        end

    a_no_commit_after_trap: assert property (@(posedge clk) disable iff (reset)
        trap_seen |-> !commit.valid)
        else begin
            $error("commit after an exception commit and before flush");
            fail_count++;
        end

endmodule

// ==== tb_rcu.sv ====
// rename unit testbench
module tb_rcu;

    localparam int rob_size = 16;
    localparam int phys_regs = 64;
    localparam int mix_count = 300;
    localparam int full_extra = 24;
    localparam int trap_count = 60;
    localparam int total_instr = mix_count + full_extra + trap_count;
    localparam int cycle_limit = 40 * total_instr;

    // result held by the emulated function unit until its slot comes
    typedef struct packed {
        logic is_lsu;
        rcu_pkg::tag_t tag;
        rcu_pkg::line_t line;
        logic [rcu_pkg::xlen-1:0] data;
        logic [31:0] due;
    } pending_wb_t;

    logic clk;
    logic reset;
    logic flush = 1'b0;
    logic dispatch_valid = 1'b0;
    rcu_pkg::dispatch_t dispatch = '0;
    logic dispatch_ready;
    logic alu_ready = 1'b0;
    logic lsu_ready = 1'b0;
    logic issue_valid;
    rcu_pkg::issue_t issue;
    rcu_pkg::wb_t wb_alu = '0;
    rcu_pkg::wb_t wb_lsu = '0;
    rcu_pkg::commit_t commit;

    // architectural model, speculative and retired
    logic [rcu_pkg::xlen-1:0] spec_regs [rcu_pkg::arch_regs];
    logic [rcu_pkg::xlen-1:0] comm_regs [rcu_pkg::arch_regs];
    logic [rcu_pkg::xlen-1:0] exp_rs1 [total_instr];
    logic [rcu_pkg::xlen-1:0] exp_rs2 [total_instr];
    logic [rcu_pkg::xlen-1:0] exp_res [total_instr];
    logic [31:0] exp_imm [total_instr];
    rcu_pkg::arch_reg_t exp_rd [total_instr];
    rcu_pkg::ecause_t exp_cause [total_instr];
    logic [total_instr-1:0] exp_wr;
    logic [total_instr-1:0] exp_exc;
    logic [total_instr-1:0] exp_lsu;

    int gen_target = 0;
    int gen_count = 0;
    int next_commit = 0;
    int next_iss = 0;
    int exc_rate = 0;
    int errors = 0;
    int checks = 0;
    int passed = 0;
    int failed = 0;
    logic hold_wb = 1'b0;
    logic trap_wait = 1'b0;
    logic cur_valid = 1'b0;
    logic held_v = 1'b0;
    rcu_pkg::issue_t held_b;
    rcu_pkg::dispatch_t cur = '0;
    logic [31:0] rng = 32'd30;
    logic [31:0] tick = '0;
    pending_wb_t pend_q [$];

    tb_clock_gen #(.period(8), .reset_cycles(5)) u_clk (.clk(clk), .reset(reset));

    rcu_top #(.rob_size(rob_size), .phys_regs(phys_regs)) UUT (
        .clk(clk), .reset(reset), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .dispatch_ready(dispatch_ready),
        .alu_ready(alu_ready), .lsu_ready(lsu_ready),
        .issue_valid(issue_valid), .issue(issue),
        .wb_alu(wb_alu), .wb_lsu(wb_lsu), .commit(commit)
    );

    bind rcu_top tb_rcu_assert u_assert (
        .clk(clk), .reset(reset), .flush(flush),
        .alu_ready(alu_ready), .lsu_ready(lsu_ready),
        .issue_valid(issue_valid), .issue(issue), .commit(commit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rcu_pkg::wb_t make_writeback(input pending_wb_t p);
        rcu_pkg::wb_t w;
        w.valid = 1'b1;
        w.tag = p.tag;
        w.data = p.data;
        w.line = p.line;
        return w;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic build_instr(output rcu_pkg::dispatch_t d);
        logic [31:0] r;
        d = '0;
        rng = xorshift32(rng);
        r = rng;
        d.pc = 32'(gen_count * 4);
        // few registers, so dependencies are frequent
        d.rs1 = rcu_pkg::arch_reg_t'(r[2:0]);
        d.rs2 = rcu_pkg::arch_reg_t'(r[5:3]);
        d.rd = rcu_pkg::arch_reg_t'(r[8:6]);
        d.use_rs1 = (r[11:9] != 3'd0);
        d.use_rs2 = (r[14:12] != 3'd0);
        d.use_rd = (r[17:15] != 3'd0);
        d.is_lsu = r[18];
        d.ecause = r[22:19];
        rng = xorshift32(rng);
        d.exception = ((rng % 32'd100) < 32'(exc_rate));
        rng = xorshift32(rng);
        d.imm = {{20{rng[11]}}, rng[11:0]};
    endtask

    // in-order execution at dispatch
    task automatic record_dispatch(input rcu_pkg::dispatch_t d);
        int s;
        s = gen_count;
        exp_rs1[s] = d.use_rs1 ? spec_regs[d.rs1] : '0;
        exp_rs2[s] = d.use_rs2 ? spec_regs[d.rs2] : '0;
        exp_res[s] = exp_rs1[s] + exp_rs2[s] + {{32{d.imm[31]}}, d.imm};
        exp_imm[s] = d.imm;
        exp_wr[s] = d.use_rd && (d.rd != '0) && !d.exception;
        exp_rd[s] = d.rd;
        exp_exc[s] = d.exception;
        exp_cause[s] = d.ecause;
        exp_lsu[s] = d.is_lsu;
        if (exp_wr[s]) begin
            spec_regs[d.rd] = exp_res[s];
        end
        gen_count++;
    endtask

    task automatic check_issue(input rcu_pkg::issue_t b);
        int s;
        s = int'(b.pc >> 2);
        if (s >= gen_count) begin
            $display("issued pc %h was never dispatched", b.pc);
            errors++;
            return;
        end
        while ((next_iss < gen_count) && exp_exc[next_iss]) begin
            next_iss++;
        end
        check("issue_order", 64'(next_iss), 64'(s));
        check("issue_exception", 64'(0), 64'(exp_exc[s]));
        check("issue_unit", 64'(exp_lsu[s]), 64'(b.is_lsu));
        // every accepted entry takes the next line, flush leaves the write side alone
        check("issue_line", 64'(s % rob_size), 64'(b.line));
        check("issue_imm", 64'(exp_imm[s]), 64'(b.imm));
        check("issue_rs1", exp_rs1[s], b.rs1_data);
        check("issue_rs2", exp_rs2[s], b.rs2_data);
        next_iss = s + 1;
    endtask

    task automatic check_commit(input rcu_pkg::commit_t c);
        int s;
        s = int'(c.pc >> 2);
        if (trap_wait) begin
            $display("commit of pc %h came after an exception and before the flush", c.pc);
            errors++;
        end
        if (s >= gen_count) begin
            $display("committed pc %h was never dispatched", c.pc);
            errors++;
            return;
        end
        check("commit_order", 64'(next_commit), 64'(s));
        check("commit_exception", 64'(exp_exc[s]), 64'(c.exception));
        if (exp_exc[s]) begin
            check("commit_cause", 64'(exp_cause[s]), 64'(c.ecause));
            trap_wait = 1'b1;
        end
        if (exp_wr[s]) begin
            comm_regs[exp_rd[s]] = exp_res[s];
        end
        next_commit = s + 1;
    endtask

    // samples the cycle that just ended, then drives the next one
    always @(posedge clk) begin : bench
        int ia;
        int il;
        logic unit_rdy;
        rcu_pkg::wb_t wa;
        rcu_pkg::wb_t wl;
        pending_wb_t pw;
        if (!reset) begin
            tick = tick + 1;
            if (flush) begin
                // younger work discarded, back to retired state
                for (int i = 0; i < rcu_pkg::arch_regs; i++) begin
                    spec_regs[i] = comm_regs[i];
                end
                next_commit = gen_count;
                next_iss = gen_count;
                trap_wait = 1'b0;
                held_v = 1'b0;
            end
            if (dispatch_valid && dispatch_ready) begin
                record_dispatch(dispatch);
                cur_valid = 1'b0;
            end
            if (held_v && !flush) begin
                check("held_valid", 64'(1), 64'(issue_valid));
                check("held_pc", 64'(held_b.pc), 64'(issue.pc));
                check("held_rs1", held_b.rs1_data, issue.rs1_data);
                check("held_rs2", held_b.rs2_data, issue.rs2_data);
            end
            unit_rdy = issue.is_lsu ? lsu_ready : alu_ready;
            held_v = issue_valid && !unit_rdy;
            held_b = issue;
            if (issue_valid && unit_rdy) begin
                check_issue(issue);
                rng = xorshift32(rng);
                pw.is_lsu = issue.is_lsu;
                pw.tag = issue.tag;
                pw.line = issue.line;
                pw.data = issue.rs1_data + issue.rs2_data + {{32{issue.imm[31]}}, issue.imm};
                pw.due = tick + 1 + (rng % 32'd6);
                pend_q.push_back(pw);
            end
            if (commit.valid) begin
                check_commit(commit);
            end

            // function units, oldest due result per port
            wa = '0;
            wl = '0;
            ia = -1;
            il = -1;
            if (!hold_wb) begin
                for (int i = 0; i < pend_q.size(); i++) begin
                    if (pend_q[i].due <= tick) begin
                        if (pend_q[i].is_lsu && (il < 0)) begin
                            il = i;
                        end else if (!pend_q[i].is_lsu && (ia < 0)) begin
                            ia = i;
                        end
                    end
                end
            end
            if (ia >= 0) begin
                wa = make_writeback(pend_q[ia]);
            end
            if (il >= 0) begin
                wl = make_writeback(pend_q[il]);
            end
            if (ia > il) begin
                pend_q.delete(ia);
                if (il >= 0) begin
                    pend_q.delete(il);
                end
            end else if (il >= 0) begin
                pend_q.delete(il);
                if (ia >= 0) begin
                    pend_q.delete(ia);
                end
            end

            // flush once every result in flight has landed
            if (trap_wait && !flush && (pend_q.size() == 0) && !wa.valid && !wl.valid) begin
                flush <= 1'b1;
            end else begin
                flush <= 1'b0;
            end

            rng = xorshift32(rng);
            if (!cur_valid && (gen_count < gen_target) && (rng[1:0] != 2'b00)) begin
                build_instr(cur);
                cur_valid = 1'b1;
            end
            dispatch_valid <= cur_valid && !trap_wait;
            dispatch <= cur;
            rng = xorshift32(rng);
            alu_ready <= !trap_wait && (rng[1:0] != 2'b00);
            lsu_ready <= !trap_wait && rng[4];
            wb_alu <= wa;
            wb_lsu <= wl;
        end
    end

    task automatic wait_drained();
        while (!((gen_count == gen_target) && (next_commit == gen_target)
                 && !trap_wait && !flush)) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : run
        int test_err;
        int base;
        for (int i = 0; i < rcu_pkg::arch_regs; i++) begin
            spec_regs[i] = '0;
            comm_regs[i] = '0;
        end
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end

        test_err = errors;
        gen_target = mix_count;
        wait_drained();
        report_test("random_order", test_err);

        // writebacks held, so the buffer fills and stays full
        test_err = errors;
        hold_wb = 1'b1;
        base = gen_count;
        gen_target = gen_target + full_extra;
        while (gen_count < base + rob_size) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        check("full_ready", 64'(0), 64'(dispatch_ready));
        check("full_count", 64'(base + rob_size), 64'(gen_count));
        hold_wb = 1'b0;
        wait_drained();
        report_test("full_buffer", test_err);

        test_err = errors;
        exc_rate = 10;
        gen_target = gen_target + trap_count;
        wait_drained();
        report_test("exception_flush", test_err);

        $display("tests %0d passed, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 passed, failed, checks, errors, UUT.u_assert.fail_count);
        if ((errors == 0) && (UUT.u_assert.fail_count == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        while (tick < cycle_limit) begin
            @(negedge clk);
        end
        $display("timeout: run did not complete within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
rcu_pkg.sv
free_tag_pool.sv
rename_map.sv
phys_regfile.sv
rob_store.sv
issue_stage.sv
rcu_top.sv
tb_clock_gen.sv
tb_rcu_assert.sv
tb_rcu.sv

// ==== Bender.yml ====
package:
  name: rcu

sources:
  - rcu_pkg.sv
  - free_tag_pool.sv
  - rename_map.sv
  - phys_regfile.sv
  - rob_store.sv
  - issue_stage.sv
  - rcu_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rcu_assert.sv
      - tb_rcu.sv
